//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - common

sources:
  - common/rvIsaPkg.sv
  - common/cpuCtrlPkg.sv
  - fetch/fetch.sv
  - decode/decode.sv
  - execute/execute.sv
  - memAccess/memAccess.sv
  - src/hazardUnit.sv
  - src/cpu.sv
  - target: test
    files:
      - testbench/cpuTb.sv

//--- common/cpuCtrlPkg.sv
package cpuCtrlPkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASSB
	} aluOpE;

	// Source of the register writeback value
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PCPLUS4} wbSelE;

endpackage

//--- common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Program and data memory depth in 32-bit words
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

// PC after reset and while the boot port is active
`define CPU_RESET_PC 32'h0000_0000

// Any address with a bit set from here upward is memory mapped
`define CPU_MMIO_LSB 15

`endif

//--- common/rvIsaPkg.sv
package rvIsaPkg;

	typedef logic [31:0] instrT;
	typedef logic [4:0] regIdxT;

	// Major opcodes handled by the decoder
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcodeE;

	// addi x0, x0, 0
	localparam instrT INSTR_NOP = 32'h0000_0013;

endpackage

//--- decode/decode.sv
module decode (
	input  logic              clk,
	input  logic              rstN,
	input  logic              debug,
	input  logic              stall,
	input  rvIsaPkg::instrT   ifInstr,
	input  logic [31:0]       ifPc,
	input  rvIsaPkg::instrT   exFwdInstr,
	input  logic [31:0]       exFwdResult,
	input  logic              exFwdRegWrite,
	input  logic              exFwdMemRead,
	input  rvIsaPkg::instrT   wbInstr,
	input  logic              wbRegWrite,
	input  logic [31:0]       wbData,
	output logic              branchTaken,
	output logic [31:0]       branchTarget,
	output logic              idEcallNow,
	output rvIsaPkg::instrT   idInstr,
	output logic [31:0]       idPc,
	output logic [31:0]       idRs1Data,
	output logic [31:0]       idRs2Data,
	output logic [31:0]       idImm,
	output cpuCtrlPkg::aluOpE idAluOp,
	output logic              idUseImm,
	output logic              idUsePc,
	output logic              idMemRead,
	output logic              idMemWrite,
	output logic              idRegWrite,
	output cpuCtrlPkg::wbSelE idWbSel,
	output logic              idEcall
);
	import rvIsaPkg::*;
	import cpuCtrlPkg::*;

	logic [31:0] regFile [32];
	opcodeE opcode;
	logic [2:0] funct3;
	regIdxT rs1;
	regIdxT rs2;
	regIdxT exRd;
	regIdxT wbRd;
	logic [31:0] rs1Val;
	logic [31:0] rs2Val;
	logic [31:0] imm;
	aluOpE aluOp;
	logic useImm;
	logic usePc;
	logic memRead;
	logic memWrite;
	logic regWrite;
	wbSelE wbSel;
	logic cond;
	logic jumpNow;
	logic ecallDone;

	assign opcode = opcodeE'(ifInstr[6:0]);
	assign funct3 = ifInstr[14:12];
	assign rs1 = ifInstr[19:15];
	assign rs2 = ifInstr[24:20];
	assign exRd = exFwdInstr[11:7];
	assign wbRd = wbInstr[11:7];

	always_ff @(posedge clk) begin
		if (wbRegWrite && wbRd != '0)
			regFile[wbRd] <= wbData;
	end

	// Newest producer first, then the register file
	function automatic logic [31:0] readOperand(regIdxT idx);
		if (idx == '0)
			return '0;
		if (exFwdRegWrite && !exFwdMemRead && exRd == idx)
			return exFwdResult;
		if (wbRegWrite && wbRd == idx)
			return wbData;
		return regFile[idx];
	endfunction

	function automatic aluOpE aluFromFunct(logic [2:0] f3, logic alt, logic isRegOp);
		case (f3)
			3'b000: return (alt && isRegOp) ? ALU_SUB : ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b100: return ALU_XOR;
			3'b101: return alt ? ALU_SRA : ALU_SRL;
			3'b110: return ALU_OR;
			3'b111: return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	assign rs1Val = readOperand(rs1);
	assign rs2Val = readOperand(rs2);

	always_comb begin
		imm = {{20{ifInstr[31]}}, ifInstr[31:20]};
		aluOp = ALU_ADD;
		useImm = 1'b0;
		usePc = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		wbSel = WB_ALU;
		case (opcode)
			OPC_LUI: begin
				imm = {ifInstr[31:12], 12'b0};
				aluOp = ALU_PASSB;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			OPC_AUIPC: begin
				imm = {ifInstr[31:12], 12'b0};
				useImm = 1'b1;
				usePc = 1'b1;
				regWrite = 1'b1;
			end
			OPC_JAL: begin
				imm = {{11{ifInstr[31]}}, ifInstr[31], ifInstr[19:12], ifInstr[20],
					ifInstr[30:21], 1'b0};
				regWrite = 1'b1;
				wbSel = WB_PCPLUS4;
			end
			OPC_JALR: begin
				regWrite = 1'b1;
				wbSel = WB_PCPLUS4;
			end
			OPC_BRANCH: begin
				imm = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7], ifInstr[30:25],
					ifInstr[11:8], 1'b0};
			end
			OPC_LOAD: begin
				useImm = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
				wbSel = WB_MEM;
			end
			OPC_STORE: begin
				imm = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			OPC_OPIMM: begin
				aluOp = aluFromFunct(funct3, ifInstr[30], 1'b0);
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			OPC_OP: begin
				aluOp = aluFromFunct(funct3, ifInstr[30], 1'b1);
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

	// Branch compare on forwarded operands
	always_comb begin
		case (funct3)
			3'b000: cond = rs1Val == rs2Val;
			3'b001: cond = rs1Val != rs2Val;
			3'b100: cond = $signed(rs1Val) < $signed(rs2Val);
			3'b101: cond = $signed(rs1Val) >= $signed(rs2Val);
			default: cond = 1'b0;
		endcase
	end

	assign jumpNow = (opcode == OPC_JAL) || (opcode == OPC_JALR) ||
		((opcode == OPC_BRANCH) && cond);
	// Operands may be stale while stalled
	assign branchTaken = jumpNow && !stall;
	assign branchTarget = (opcode == OPC_JALR) ? ((rs1Val + imm) & ~32'd1) : (ifPc + imm);
	assign idEcallNow = (opcode == OPC_SYSTEM);

	// Only the first ECALL goes down the pipe, bubbles after it
	always_ff @(posedge clk) begin
		if (!rstN || debug)
			ecallDone <= 1'b0;
		else if (idEcallNow && !stall)
			ecallDone <= 1'b1;
	end

	// Decode/execute register
	always_ff @(posedge clk) begin
		if (!rstN || debug || stall || ecallDone) begin
			idInstr <= INSTR_NOP;
			idAluOp <= ALU_ADD;
			idUseImm <= 1'b0;
			idUsePc <= 1'b0;
			idMemRead <= 1'b0;
			idMemWrite <= 1'b0;
			idRegWrite <= 1'b0;
			idWbSel <= WB_ALU;
			idEcall <= 1'b0;
		end else begin
			idInstr <= ifInstr;
			idAluOp <= aluOp;
			idUseImm <= useImm;
			idUsePc <= usePc;
			idMemRead <= memRead;
			idMemWrite <= memWrite;
			idRegWrite <= regWrite;
			idWbSel <= wbSel;
			idEcall <= idEcallNow;
		end
	end

	always_ff @(posedge clk) begin
		idPc <= ifPc;
		idRs1Data <= rs1Val;
		idRs2Data <= rs2Val;
		idImm <= imm;
	end

	// x0 never reaches execute as anything but zero
	assertX0Zero: assert property (@(posedge clk) disable iff (!rstN)
		(rs1 == '0) |=> (idRs1Data == '0));

endmodule

//--- execute/execute.sv
module execute (
	input  logic              clk,
	input  logic              rstN,
	input  logic              debug,
	input  rvIsaPkg::instrT   idInstr,
	input  logic [31:0]       idPc,
	input  logic [31:0]       idRs1Data,
	input  logic [31:0]       idRs2Data,
	input  logic [31:0]       idImm,
	input  cpuCtrlPkg::aluOpE idAluOp,
	input  logic              idUseImm,
	input  logic              idUsePc,
	input  logic              idMemRead,
	input  logic              idMemWrite,
	input  logic              idRegWrite,
	input  cpuCtrlPkg::wbSelE idWbSel,
	input  logic              idEcall,
	input  rvIsaPkg::instrT   wbInstr,
	input  logic              wbRegWrite,
	input  logic [31:0]       wbData,
	output rvIsaPkg::instrT   exInstr,
	output logic [31:0]       exPc,
	output logic [31:0]       exResult,
	output logic [31:0]       exStoreData,
	output logic              exMemRead,
	output logic              exMemWrite,
	output logic              exRegWrite,
	output cpuCtrlPkg::wbSelE exWbSel,
	output logic              exEcall
);
	import rvIsaPkg::*;
	import cpuCtrlPkg::*;

	regIdxT exRd;
	regIdxT wbRd;
	logic [31:0] fwd1;
	logic [31:0] fwd2;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluOut;

	assign exRd = exInstr[11:7];
	assign wbRd = wbInstr[11:7];

	// Load data is never in the execute/memory register, the load-use stall covers it
	function automatic logic [31:0] forward(regIdxT idx, logic [31:0] fromId);
		if (idx == '0)
			return fromId;
		if (exRegWrite && !exMemRead && exRd == idx)
			return exResult;
		if (wbRegWrite && wbRd == idx)
			return wbData;
		return fromId;
	endfunction

	assign fwd1 = forward(idInstr[19:15], idRs1Data);
	assign fwd2 = forward(idInstr[24:20], idRs2Data);
	assign opA = idUsePc ? idPc : fwd1;
	assign opB = idUseImm ? idImm : fwd2;

	always_comb begin
		case (idAluOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_AND: aluOut = opA & opB;
			ALU_OR: aluOut = opA | opB;
			ALU_XOR: aluOut = opA ^ opB;
			ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
			ALU_SLL: aluOut = opA << opB[4:0];
			ALU_SRL: aluOut = opA >> opB[4:0];
			ALU_SRA: aluOut = $unsigned($signed(opA) >>> opB[4:0]);
			ALU_PASSB: aluOut = opB;
			default: aluOut = opA + opB;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk) begin
		if (!rstN || debug) begin
			exInstr <= INSTR_NOP;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exRegWrite <= 1'b0;
			exWbSel <= WB_ALU;
			exEcall <= 1'b0;
		end else begin
			exInstr <= idInstr;
			exMemRead <= idMemRead;
			exMemWrite <= idMemWrite;
			exRegWrite <= idRegWrite;
			exWbSel <= idWbSel;
			exEcall <= idEcall;
		end
	end

	// Jumps carry the link value so later forwarding sees it
	always_ff @(posedge clk) begin
		exPc <= idPc;
		exResult <= (idWbSel == WB_PCPLUS4) ? idPc + 32'd4 : aluOut;
		exStoreData <= fwd2;
	end

endmodule

//--- fetch/fetch.sv
`include "cpu_defines.svh"

module fetch (
	input  logic            clk,
	input  logic            rstN,
	input  logic            debug,
	input  logic            stall,
	input  logic            flushIf,
	input  logic            branchTaken,
	input  logic [31:0]     branchTarget,
	input  logic [31:0]     bootAddr,
	input  logic [31:0]     bootData,
	output rvIsaPkg::instrT ifInstr,
	output logic [31:0]     ifPc
);
	import rvIsaPkg::*;

	localparam int ImemAw = $clog2(`CPU_IMEM_WORDS);

	logic [31:0] imem [`CPU_IMEM_WORDS];
	logic [31:0] pc;
	instrT fetched;

	// Boot loader writes one word per clock
	always_ff @(posedge clk) begin
		if (debug)
			imem[bootAddr[ImemAw+1:2]] <= bootData;
	end

	assign fetched = imem[pc[ImemAw+1:2]];

	always_ff @(posedge clk) begin
		if (!rstN || debug)
			pc <= `CPU_RESET_PC;
		else if (branchTaken)
			pc <= branchTarget;
		else if (!stall)
			pc <= pc + 32'd4;
	end

	// Fetch/decode register
	always_ff @(posedge clk) begin
		if (!rstN || debug || flushIf) begin
			ifInstr <= INSTR_NOP;
			ifPc <= `CPU_RESET_PC;
		end else if (!stall) begin
			ifInstr <= fetched;
			ifPc <= pc;
		end
	end

endmodule

//--- memAccess/memAccess.sv
`include "cpu_defines.svh"

module memAccess (
	input  logic              clk,
	input  logic              rstN,
	input  logic              debug,
	input  rvIsaPkg::instrT   exInstr,
	input  logic [31:0]       exPc,
	input  logic [31:0]       exResult,
	input  logic [31:0]       exStoreData,
	input  logic              exMemRead,
	input  logic              exMemWrite,
	input  logic              exRegWrite,
	input  cpuCtrlPkg::wbSelE exWbSel,
	input  logic              exEcall,
	input  logic [31:0]       joystickData,
	output logic [31:0]       memMappedAddr,
	output logic [31:0]       memMappedDataOut,
	output rvIsaPkg::instrT   wbInstr,
	output logic              wbRegWrite,
	output logic [31:0]       wbData,
	output logic              halt
);
	import rvIsaPkg::*;
	import cpuCtrlPkg::*;

	localparam int DmemAw = $clog2(`CPU_DMEM_WORDS);

	logic [31:0] dmem [`CPU_DMEM_WORDS];
	logic [DmemAw-1:0] dmemIdx;
	logic isMmio;
	logic mmioStore;
	logic [31:0] loadData;
	logic [31:0] wbDataNext;

	assign isMmio = |exResult[31:`CPU_MMIO_LSB];
	assign dmemIdx = exResult[DmemAw+1:2];
	assign mmioStore = exMemWrite && isMmio;

	always_ff @(posedge clk) begin
		if (exMemWrite && !isMmio)
			dmem[dmemIdx] <= exStoreData;
	end

	// Joystick is the only MMIO read source
	assign loadData = (exMemRead && isMmio) ? joystickData : dmem[dmemIdx];

	// Idle value is all ones
	assign memMappedAddr = mmioStore ? exResult : '1;
	assign memMappedDataOut = mmioStore ? exStoreData : '1;

	// Link value already arrives in exResult from execute
	always_comb begin
		case (exWbSel)
			WB_MEM: wbDataNext = loadData;
			default: wbDataNext = exResult;
		endcase
	end

	// Memory/writeback register and sticky halt
	always_ff @(posedge clk) begin
		if (!rstN || debug) begin
			wbInstr <= INSTR_NOP;
			wbRegWrite <= 1'b0;
			halt <= 1'b0;
		end else begin
			wbInstr <= exInstr;
			wbRegWrite <= exRegWrite;
			if (exEcall)
				halt <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		wbData <= wbDataNext;
	end

	// Nothing reaches the bus once halted
	assertMmioIdle: assert property (@(posedge clk) disable iff (!rstN)
		(halt || !exMemWrite) |-> (memMappedAddr == '1) && (memMappedDataOut == '1));

endmodule

//--- src/cpu.sv
module cpu (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] bootAddr,
	input  logic [31:0] bootData,
	input  logic        debug,
	input  logic [31:0] joystickData,
	output logic [31:0] memMappedAddr,
	output logic [31:0] memMappedDataOut,
	output logic        halt
);
	import rvIsaPkg::*;
	import cpuCtrlPkg::*;

	instrT ifInstr;
	logic [31:0] ifPc;
	logic branchTaken;
	logic [31:0] branchTarget;
	logic idEcallNow;
	instrT idInstr;
	logic [31:0] idPc;
	logic [31:0] idRs1Data;
	logic [31:0] idRs2Data;
	logic [31:0] idImm;
	aluOpE idAluOp;
	logic idUseImm;
	logic idUsePc;
	logic idMemRead;
	logic idMemWrite;
	logic idRegWrite;
	wbSelE idWbSel;
	logic idEcall;
	instrT exInstr;
	logic [31:0] exPc;
	logic [31:0] exResult;
	logic [31:0] exStoreData;
	logic exMemRead;
	logic exMemWrite;
	logic exRegWrite;
	wbSelE exWbSel;
	logic exEcall;
	instrT wbInstr;
	logic wbRegWrite;
	logic [31:0] wbData;
	logic stall;
	logic flushIf;
	logic freezePc;

	// ECALL freeze holds fetch but still lets decode issue
	fetch iFetch (
		.clk(clk), .rstN(rstN), .debug(debug),
		.stall(stall | freezePc), .flushIf(flushIf),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.bootAddr(bootAddr), .bootData(bootData),
		.ifInstr(ifInstr), .ifPc(ifPc)
	);

	decode iDecode (
		.clk(clk), .rstN(rstN), .debug(debug), .stall(stall),
		.ifInstr(ifInstr), .ifPc(ifPc),
		.exFwdInstr(exInstr), .exFwdResult(exResult),
		.exFwdRegWrite(exRegWrite), .exFwdMemRead(exMemRead),
		.wbInstr(wbInstr), .wbRegWrite(wbRegWrite), .wbData(wbData),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .idEcallNow(idEcallNow),
		.idInstr(idInstr), .idPc(idPc), .idRs1Data(idRs1Data), .idRs2Data(idRs2Data),
		.idImm(idImm), .idAluOp(idAluOp), .idUseImm(idUseImm), .idUsePc(idUsePc),
		.idMemRead(idMemRead), .idMemWrite(idMemWrite), .idRegWrite(idRegWrite),
		.idWbSel(idWbSel), .idEcall(idEcall)
	);

	execute iExecute (
		.clk(clk), .rstN(rstN), .debug(debug),
		.idInstr(idInstr), .idPc(idPc), .idRs1Data(idRs1Data), .idRs2Data(idRs2Data),
		.idImm(idImm), .idAluOp(idAluOp), .idUseImm(idUseImm), .idUsePc(idUsePc),
		.idMemRead(idMemRead), .idMemWrite(idMemWrite), .idRegWrite(idRegWrite),
		.idWbSel(idWbSel), .idEcall(idEcall),
		.wbInstr(wbInstr), .wbRegWrite(wbRegWrite), .wbData(wbData),
		.exInstr(exInstr), .exPc(exPc), .exResult(exResult), .exStoreData(exStoreData),
		.exMemRead(exMemRead), .exMemWrite(exMemWrite), .exRegWrite(exRegWrite),
		.exWbSel(exWbSel), .exEcall(exEcall)
	);

	memAccess iMemAccess (
		.clk(clk), .rstN(rstN), .debug(debug),
		.exInstr(exInstr), .exPc(exPc), .exResult(exResult), .exStoreData(exStoreData),
		.exMemRead(exMemRead), .exMemWrite(exMemWrite), .exRegWrite(exRegWrite),
		.exWbSel(exWbSel), .exEcall(exEcall), .joystickData(joystickData),
		.memMappedAddr(memMappedAddr), .memMappedDataOut(memMappedDataOut),
		.wbInstr(wbInstr), .wbRegWrite(wbRegWrite), .wbData(wbData), .halt(halt)
	);

	// Decode-stage word feeds both source and opcode checks
	hazardUnit iHazardUnit (
		.ifInstr(ifInstr), .idInstrNow(ifInstr),
		.idInstr(idInstr), .idRegWrite(idRegWrite), .idMemRead(idMemRead),
		.exInstr(exInstr), .exMemRead(exMemRead),
		.branchTaken(branchTaken), .idEcallNow(idEcallNow),
		.stall(stall), .flushIf(flushIf), .freezePc(freezePc)
	);

endmodule

//--- src/hazardUnit.sv
module hazardUnit (
	input  rvIsaPkg::instrT ifInstr,
	input  rvIsaPkg::instrT idInstrNow,
	input  rvIsaPkg::instrT idInstr,
	input  logic            idRegWrite,
	input  logic            idMemRead,
	input  rvIsaPkg::instrT exInstr,
	input  logic            exMemRead,
	input  logic            branchTaken,
	input  logic            idEcallNow,
	output logic            stall,
	output logic            flushIf,
	output logic            freezePc
);
	import rvIsaPkg::*;

	opcodeE opcode;
	regIdxT rs1;
	regIdxT rs2;
	regIdxT exeRd;
	regIdxT memRd;
	logic usesRs1;
	logic usesRs2;
	logic isBranchOp;
	logic hitExe;
	logic hitMem;

	assign opcode = opcodeE'(idInstrNow[6:0]);
	assign rs1 = ifInstr[19:15];
	assign rs2 = ifInstr[24:20];
	assign exeRd = idInstr[11:7];
	assign memRd = exInstr[11:7];

	always_comb begin
		usesRs1 = 1'b0;
		usesRs2 = 1'b0;
		case (opcode)
			OPC_JALR, OPC_LOAD, OPC_OPIMM: usesRs1 = 1'b1;
			OPC_BRANCH, OPC_STORE, OPC_OP: begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			default: ;
		endcase
	end

	assign hitExe = (usesRs1 && rs1 != '0 && rs1 == exeRd) ||
		(usesRs2 && rs2 != '0 && rs2 == exeRd);
	assign hitMem = (usesRs1 && rs1 != '0 && rs1 == memRd) ||
		(usesRs2 && rs2 != '0 && rs2 == memRd);
	assign isBranchOp = (opcode == OPC_BRANCH) || (opcode == OPC_JALR);

	// Load-use, then branch operands from execute, then a load one stage further
	assign stall = (idMemRead && hitExe) || (isBranchOp && idRegWrite && hitExe) ||
		(isBranchOp && exMemRead && hitMem);
	assign flushIf = branchTaken;
	assign freezePc = idEcallNow;

	// Decode withholds the redirect while operands are not ready
	assertNoFlushInStall: assert final (!(flushIf === 1'b1 && stall === 1'b1));

endmodule

//--- testbench/cpuTb.sv
module cpuTb;
	import rvIsaPkg::*;

	localparam int ClkPeriod = 10;
	localparam int ResetCycles = 5;
	localparam int ProgWords = 32;
	localparam int LoopWord = 20;
	localparam int JalWord = 24;
	localparam int SubWord = 30;
	localparam int ExpStores = 5;
	localparam logic [31:0] MmioBase = 32'h0000_8000;
	// Reset and boot, then twenty cycles per program word
	localparam int TimeoutCycles = ResetCycles + ProgWords + 20 * ProgWords;

	logic clk;
	logic rstN;
	logic [31:0] bootAddr;
	logic [31:0] bootData;
	logic debug;
	logic [31:0] joystickData;
	logic [31:0] memMappedAddr;
	logic [31:0] memMappedDataOut;
	logic halt;
	instrT prog [ProgWords];
	logic [31:0] expAddr [ExpStores];
	logic [31:0] expData [ExpStores];
	int storeCount = 0;
	logic started = 1'b0;
	integer seed;

	cpu i_dut (
		.clk(clk), .rstN(rstN), .bootAddr(bootAddr), .bootData(bootData),
		.debug(debug), .joystickData(joystickData),
		.memMappedAddr(memMappedAddr), .memMappedDataOut(memMappedDataOut), .halt(halt)
	);

	// RV32I encoders
	function automatic instrT rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic instrT iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic instrT sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic instrT bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic instrT jType(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic instrT uType(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	task automatic failRun(string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic buildProgram();
		// Dependent ALU chain, result to MMIO
		prog[0] = iType(12'd5, 5'd0, 3'b000, 5'd1, OPC_OPIMM);
		prog[1] = iType(12'd3, 5'd1, 3'b000, 5'd2, OPC_OPIMM);
		prog[2] = iType(12'd2, 5'd2, 3'b001, 5'd3, OPC_OPIMM);
		prog[3] = rType(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4);
		prog[4] = rType(7'b0, 5'd4, 5'd1, 3'b010, 5'd5);
		prog[5] = rType(7'b0, 5'd5, 5'd4, 3'b100, 5'd6);
		prog[6] = rType(7'b0, 5'd3, 5'd6, 3'b110, 5'd6);
		prog[7] = iType(12'(-64), 5'd0, 3'b000, 5'd7, OPC_OPIMM);
		prog[8] = iType(12'h402, 5'd7, 3'b101, 5'd7, OPC_OPIMM);
		prog[9] = rType(7'b0, 5'd7, 5'd6, 3'b000, 5'd6);
		prog[10] = uType(MmioBase[31:12], 5'd10, OPC_LUI);
		prog[11] = sType(12'd0, 5'd6, 5'd10);
		// Data memory round trip with load-use
		prog[12] = iType(12'd100, 5'd0, 3'b000, 5'd11, OPC_OPIMM);
		prog[13] = sType(12'd8, 5'd6, 5'd11);
		prog[14] = iType(12'd8, 5'd11, 3'b010, 5'd12, OPC_LOAD);
		prog[15] = rType(7'b0, 5'd1, 5'd12, 3'b000, 5'd13);
		prog[16] = sType(12'd4, 5'd13, 5'd10);
		// Sum 1..10 with a BNE loop
		prog[17] = iType(12'd0, 5'd0, 3'b000, 5'd14, OPC_OPIMM);
		prog[18] = iType(12'd1, 5'd0, 3'b000, 5'd15, OPC_OPIMM);
		prog[19] = iType(12'd11, 5'd0, 3'b000, 5'd16, OPC_OPIMM);
		prog[LoopWord] = rType(7'b0, 5'd15, 5'd14, 3'b000, 5'd14);
		prog[21] = iType(12'd1, 5'd15, 3'b000, 5'd15, OPC_OPIMM);
		prog[22] = bType(13'((LoopWord - 22) * 4), 5'd16, 5'd15, 3'b001);
		prog[23] = sType(12'd8, 5'd14, 5'd10);
		// Call and return
		prog[JalWord] = jType(21'((SubWord - JalWord) * 4), 5'd1);
		prog[25] = sType(12'd12, 5'd17, 5'd10);
		// Joystick read plus one
		prog[26] = iType(12'd16, 5'd10, 3'b010, 5'd18, OPC_LOAD);
		prog[27] = iType(12'd1, 5'd18, 3'b000, 5'd19, OPC_OPIMM);
		prog[28] = sType(12'd16, 5'd19, 5'd10);
		prog[29] = iType(12'd0, 5'd0, 3'b000, 5'd0, OPC_SYSTEM);
		prog[SubWord] = iType(12'd100, 5'd1, 3'b000, 5'd17, OPC_OPIMM);
		prog[31] = iType(12'd0, 5'd1, 3'b000, 5'd0, OPC_JALR);
	endtask

	task automatic computeExpected();
		logic [31:0] r1;
		logic [31:0] r3;
		logic [31:0] r4;
		logic [31:0] r5;
		logic [31:0] r6;
		logic [31:0] sum;
		r1 = 32'd5;
		r3 = (r1 + 32'd3) << 2;
		r4 = r3 - r1;
		r5 = ($signed(r1) < $signed(r4)) ? 32'd1 : 32'd0;
		r6 = ((r4 ^ r5) | r3) + $unsigned($signed(32'hFFFF_FFC0) >>> 2);
		sum = '0;
		for (int k = 1; k <= 10; k++)
			sum = sum + k;
		expAddr[0] = MmioBase;
		expData[0] = r6;
		expAddr[1] = MmioBase + 32'd4;
		expData[1] = r6 + r1;
		expAddr[2] = MmioBase + 32'd8;
		expData[2] = sum;
		// Link of the JAL plus the subroutine's offset
		expAddr[3] = MmioBase + 32'd12;
		expData[3] = JalWord * 4 + 4 + 100;
		expAddr[4] = MmioBase + 32'd16;
		expData[4] = joystickData + 32'd1;
	endtask

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		started <= 1'b1;
		if (rstN && memMappedAddr != 32'hFFFF_FFFF)
			storeCount <= storeCount + 1;
	end

	assertIdle: assert property (@(posedge clk)
		(started && (!rstN || debug)) |->
			(!halt && memMappedAddr == '1 && memMappedDataOut == '1))
		else failRun($sformatf("FAILED at %0t: outputs not idle in reset or boot", $time));

	// Stores in program order against the expected list
	assertStore: assert property (@(posedge clk) disable iff (!rstN)
		(memMappedAddr != '1) |-> (storeCount < ExpStores &&
			memMappedAddr == expAddr[storeCount] && memMappedDataOut == expData[storeCount]))
		else failRun($sformatf("FAILED at %0t: MMIO store %0d wrote %h to %h", $time,
			$sampled(storeCount), $sampled(memMappedDataOut), $sampled(memMappedAddr)));

	assertHaltSticky: assert property (@(posedge clk) disable iff (!rstN || debug)
		halt |=> halt)
		else failRun($sformatf("FAILED at %0t: halt dropped after ECALL", $time));

	assertQuietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
		halt |-> (memMappedAddr == '1 && memMappedDataOut == '1))
		else failRun($sformatf("FAILED at %0t: MMIO store after halt", $time));

	initial begin
		seed = 96269;
		rstN = 1'b0;
		debug = 1'b0;
		bootAddr = '0;
		bootData = '0;
		joystickData = $random(seed);
		buildProgram();
		computeExpected();
		repeat (ResetCycles) @(negedge clk);
		rstN = 1'b1;
		debug = 1'b1;
		for (int i = 0; i < ProgWords; i++) begin
			bootAddr = i * 4;
			bootData = prog[i];
			@(negedge clk);
		end
		debug = 1'b0;
		wait (halt === 1'b1);
		// Let the frozen pipeline run a while
		repeat (10) @(negedge clk);
		if (storeCount == ExpStores) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			failRun($sformatf("FAILED at %0t: saw %0d MMIO stores, expected %0d", $time,
				storeCount, ExpStores));
		end
	end

	initial begin
		#(TimeoutCycles * ClkPeriod);
		failRun("Timeout: the CPU did not reach ECALL within the cycle budget");
	end

endmodule

//--- verilog.f
+incdir+common
common/rvIsaPkg.sv
common/cpuCtrlPkg.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
memAccess/memAccess.sv
src/hazardUnit.sv
src/cpu.sv
testbench/cpuTb.sv
